//--- hdl/sensor_hub_pkg.sv
package sensor_hub_pkg;

    // Address map, 128K byte aperture
    localparam int ADDR_W     = 17;
    localparam int REGION_LSB = 12;

    localparam logic [ADDR_W-1:0] REG_BASE   = 17'h00000;
    localparam logic [ADDR_W-1:0] DPORT_BASE = 17'h11000;

    // Register word indices, address bits 8:2
    localparam logic [6:0] REG_ID_ADR        = 7'h0;
    localparam logic [6:0] REG_REV_ADR       = 7'h1;
    localparam logic [6:0] REG_FIFO_RST_ADR  = 7'h2;
    localparam logic [6:0] REG_SENSOR_EN_ADR = 7'h3;
    localparam logic [6:0] REG_STATUS_ADR    = 7'h4;
    localparam logic [6:0] REG_SCRATCH_ADR   = 7'h5;

    localparam logic [31:0] DEVICE_ID        = 32'h0000_5E45;
    localparam logic [31:0] REV_LEVEL        = 32'h0000_0100;
    localparam logic [31:0] SCRATCH_RESET    = 32'h1234_5678;
    localparam logic [31:0] DEF_REG_VALUE    = 32'hFABD_EFAC; // Hole in register space
    localparam logic [31:0] BAD_READ_VALUE   = 32'hBADF_ABAC; // Unmapped region
    localparam logic [31:0] EMPTY_READ_VALUE = 32'hDEFF_ABAC; // Data port with no samples

    localparam int DEFAULT_TIMEOUT = 7; // Cycles until an unmapped access is acked

    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [3:0]        sel;
        logic              we;
        logic              cyc;
        logic              stb;
        logic [31:0]       dat;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    typedef enum logic [1:0] {REGION_REGS, REGION_DPORT, REGION_NONE} region_t;
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_START, SEQ_WAIT} seq_state_t;
    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_END} spi_state_t;

    // Read back as the STATUS register
    typedef struct packed {
        logic       overrun;
        logic       empty;
        logic       full;
        logic [8:0] level;
    } fifo_status_t;

endpackage

//--- hdl/wb_addr_decode.sv
`timescale 1ns/1ps

module wb_addr_decode
    import sensor_hub_pkg::*;
(
    input  logic    wbs_clk_i,
    input  logic    rst_i,
    input  wb_req_t wb_req_i,
    input  wb_rsp_t regs_rsp_i,
    output logic    reg_sel_o,
    output logic    dport_sel_o,
    output wb_rsp_t wb_rsp_o
);

    localparam logic [2:0] TMO_LAST = 3'(DEFAULT_TIMEOUT - 1);

    region_t    region;
    logic       bus_req;
    logic       none_sel;
    logic [2:0] tmo_cnt;
    logic       def_ack;

    always_comb
    begin
        if (wb_req_i.adr[ADDR_W-1:REGION_LSB] == REG_BASE[ADDR_W-1:REGION_LSB])
            region = REGION_REGS;
        else if (wb_req_i.adr[ADDR_W-1:REGION_LSB] == DPORT_BASE[ADDR_W-1:REGION_LSB])
            region = REGION_DPORT;
        else
            region = REGION_NONE;
    end

    assign bus_req     = wb_req_i.cyc & wb_req_i.stb;
    assign reg_sel_o   = bus_req && (region == REGION_REGS);
    assign dport_sel_o = bus_req && (region == REGION_DPORT);
    assign none_sel    = bus_req && (region == REGION_NONE);

    // Nobody answers an unmapped access, so time it out here
    always_ff @(posedge wbs_clk_i)
    begin
        if (rst_i)
        begin
            tmo_cnt <= '0;
            def_ack <= 1'b0;
        end
        else
        begin
            def_ack <= 1'b0;
            if (!wb_req_i.stb)
                tmo_cnt <= '0;  // Restart on every new access
            else if (none_sel && !def_ack)
            begin
                if (tmo_cnt == TMO_LAST)
                begin
                    def_ack <= 1'b1;
                    tmo_cnt <= '0;
                end
                else
                    tmo_cnt <= tmo_cnt + 1'b1;
            end
        end
    end

    always_comb
    begin
        wb_rsp_o.ack = regs_rsp_i.ack | def_ack;
        wb_rsp_o.dat = (region == REGION_NONE) ? BAD_READ_VALUE : regs_rsp_i.dat;
    end

    // Merged ack from either source stays inside a live bus cycle
    a_ack_in_cycle: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
        wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb));

endmodule

//--- hdl/fabric_regs.sv
`timescale 1ns/1ps

module fabric_regs
    import sensor_hub_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
)
(
    input  logic         wbs_clk_i,
    input  logic         rst_i,
    input  wb_req_t      wb_req_i,
    input  logic         reg_sel_i,
    input  logic         dport_sel_i,
    output wb_rsp_t      wb_rsp_o,
    output logic         sensor_en_o,
    output logic         fifo_clr_o,
    output logic         fifo_pop_o,
    input  fifo_status_t fifo_status_i,
    input  logic [31:0]  fifo_data_i
);

    // STATUS level field is 9 bits wide
    if (FIFO_DEPTH_LOG2 > 8)
    begin : g_depth_check
        $error("FIFO depth does not fit the STATUS level field");
    end

    logic [6:0]  reg_idx;
    logic        ack_q;
    logic        reg_wr;
    logic [31:0] scratch_q;
    logic        sensor_en_q;

    assign reg_idx = wb_req_i.adr[8:2];
    assign reg_wr  = reg_sel_i & wb_req_i.we & ack_q; // Commit on the ack edge

    always_ff @(posedge wbs_clk_i)
    begin
        if (rst_i)
        begin
            ack_q       <= 1'b0;
            sensor_en_q <= 1'b0;
            scratch_q   <= SCRATCH_RESET;
        end
        else
        begin
            ack_q <= (reg_sel_i | dport_sel_i) & ~ack_q;  // Single-cycle ack
            if (reg_wr && reg_idx == REG_SENSOR_EN_ADR && wb_req_i.sel[0])
                sensor_en_q <= wb_req_i.dat[0];
            if (reg_wr && reg_idx == REG_SCRATCH_ADR)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (wb_req_i.sel[b])
                        scratch_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
    end

    assign fifo_clr_o  = reg_wr && (reg_idx == REG_FIFO_RST_ADR);
    assign fifo_pop_o  = dport_sel_i & ~wb_req_i.we & ack_q & ~fifo_status_i.empty;
    assign sensor_en_o = sensor_en_q;

    always_comb
    begin
        wb_rsp_o.ack = ack_q;
        if (dport_sel_i)
            wb_rsp_o.dat = fifo_status_i.empty ? EMPTY_READ_VALUE : fifo_data_i;
        else
        begin
            case (reg_idx)
                REG_ID_ADR:        wb_rsp_o.dat = DEVICE_ID;
                REG_REV_ADR:       wb_rsp_o.dat = REV_LEVEL;
                REG_SENSOR_EN_ADR: wb_rsp_o.dat = {31'b0, sensor_en_q};
                REG_STATUS_ADR:    wb_rsp_o.dat = {20'b0, fifo_status_i};
                REG_SCRATCH_ADR:   wb_rsp_o.dat = scratch_q;
                default:           wb_rsp_o.dat = DEF_REG_VALUE;
            endcase
        end
    end

    // Pop only for a data-port read held since the previous cycle
    a_pop_after_request: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
        fifo_pop_o |-> $past(dport_sel_i && !wb_req_i.we));

endmodule

//--- hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
    import sensor_hub_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
)
(
    input  logic         wbs_clk_i,
    input  logic         rst_i,
    input  logic         clr_i,
    input  logic         push_i,
    input  logic [31:0]  data_i,
    input  logic         pop_i,
    output logic [31:0]  data_o,
    output fifo_status_t status_o
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    logic [31:0]                mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       full;
    logic                       empty;
    logic                       overrun_q;
    logic                       push_ok;
    logic                       pop_ok;

    assign full    = (count == (FIFO_DEPTH_LOG2+1)'(DEPTH));
    assign empty   = (count == '0);
    assign push_ok = push_i & ~full;  // Sensor is never stalled, excess is lost
    assign pop_ok  = pop_i & ~empty;

    always_ff @(posedge wbs_clk_i)
    begin
        if (rst_i || clr_i)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overrun_q <= 1'b0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;
            if (push_i && full)
                overrun_q <= 1'b1;  // Sticky until cleared
        end
    end

    always_ff @(posedge wbs_clk_i)
    begin
        if (push_ok)
            mem[wr_ptr] <= data_i;
    end

    assign data_o = mem[rd_ptr];  // First-word view of the head

    always_comb
    begin
        status_o.overrun = overrun_q;
        status_o.empty   = empty;
        status_o.full    = full;
        status_o.level   = 9'(count);
    end

endmodule

//--- hdl/acq_sequencer.sv
`timescale 1ns/1ps

module acq_sequencer
    import sensor_hub_pkg::*;
(
    input  logic wbs_clk_i,
    input  logic rst_i,
    input  logic sensor_en_i,
    input  logic spi_done_i,
    output logic spi_start_o
);

    seq_state_t state_q;
    seq_state_t state_d;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE:
                if (sensor_en_i)
                    state_d = SEQ_START;
            SEQ_START:
                state_d = SEQ_WAIT;  // One-cycle start pulse
            SEQ_WAIT:
                // Disable lets the running word finish first
                if (spi_done_i)
                    state_d = sensor_en_i ? SEQ_START : SEQ_IDLE;
            default:
                state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge wbs_clk_i)
    begin
        if (rst_i)
            state_q <= SEQ_IDLE;
        else
            state_q <= state_d;
    end

    assign spi_start_o = (state_q == SEQ_START);

endmodule

//--- hdl/spi_deserializer.sv
`timescale 1ns/1ps

module spi_deserializer
    import sensor_hub_pkg::*;
#(
    parameter int SCLK_DIV = 2
)
(
    input  logic        wbs_clk_i,
    input  logic        rst_i,
    input  logic        spi_start_i,
    output logic        spi_done_o,
    output logic        cs_n_o,
    output logic        sclk_o,
    input  logic        sdata_i,
    output logic [31:0] sample_data_o,
    output logic        sample_push_o
);

    localparam int DIV_W = $clog2(SCLK_DIV + 1);

    spi_state_t  state_q;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]  bit_cnt;
    logic        sclk_q;
    logic        cs_n_q;
    logic        div_done;
    logic [31:0] shift_q;

    assign div_done = (div_cnt == DIV_W'(SCLK_DIV - 1)); // End of a half period

    always_ff @(posedge wbs_clk_i)
    begin
        if (rst_i)
        begin
            state_q <= SPI_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
            cs_n_q  <= 1'b1;
        end
        else
        begin
            case (state_q)
                SPI_IDLE:
                    if (spi_start_i)
                    begin
                        state_q <= SPI_SHIFT;
                        cs_n_q  <= 1'b0;
                    end
                SPI_SHIFT:
                    if (div_done)
                    begin
                        div_cnt <= '0;
                        sclk_q  <= ~sclk_q;
                        if (sclk_q)  // Falling edge closes a bit
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 5'd31)
                            begin
                                state_q <= SPI_END;
                                cs_n_q  <= 1'b1;
                            end
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                default:
                    state_q <= SPI_IDLE;  // SPI_END lasts one cycle
            endcase
        end
    end

    // Sample where sclk is raised, MSB arrives first
    always_ff @(posedge wbs_clk_i)
    begin
        if (state_q == SPI_SHIFT && div_done && !sclk_q)
            shift_q <= {shift_q[30:0], sdata_i};
    end

    assign spi_done_o    = (state_q == SPI_END);
    assign sample_push_o = (state_q == SPI_END);  // Word goes to the FIFO with done
    assign sample_data_o = shift_q;
    assign cs_n_o        = cs_n_q;
    assign sclk_o        = sclk_q;

    a_sclk_in_frame: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
        $changed(sclk_o) |-> $past(!cs_n_o));

endmodule

//--- hdl/sensor_hub_top.sv
`timescale 1ns/1ps

module sensor_hub_top
    import sensor_hub_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3,
    parameter int SCLK_DIV        = 2
)
(
    input  logic    wbs_clk_i,
    input  logic    rst_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    output logic    cs_n_o,
    output logic    sclk_o,
    input  logic    sdata_i
);

    wb_rsp_t      regs_rsp;
    logic         reg_sel;
    logic         dport_sel;
    logic         sensor_en;
    logic         fifo_clr;
    logic         fifo_pop;
    fifo_status_t fifo_status;
    logic [31:0]  fifo_head;
    logic         spi_start;
    logic         spi_done;
    logic [31:0]  sample_data;
    logic         sample_push;

    wb_addr_decode u_wb_addr_decode (
        .wbs_clk_i   (wbs_clk_i),
        .rst_i       (rst_i),
        .wb_req_i    (wb_req_i),
        .regs_rsp_i  (regs_rsp),
        .reg_sel_o   (reg_sel),
        .dport_sel_o (dport_sel),
        .wb_rsp_o    (wb_rsp_o)
    );

    fabric_regs #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fabric_regs (
        .wbs_clk_i     (wbs_clk_i),
        .rst_i         (rst_i),
        .wb_req_i      (wb_req_i),
        .reg_sel_i     (reg_sel),
        .dport_sel_i   (dport_sel),
        .wb_rsp_o      (regs_rsp),
        .sensor_en_o   (sensor_en),
        .fifo_clr_o    (fifo_clr),
        .fifo_pop_o    (fifo_pop),
        .fifo_status_i (fifo_status),
        .fifo_data_i   (fifo_head)
    );

    sample_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_sample_fifo (
        .wbs_clk_i (wbs_clk_i),
        .rst_i     (rst_i),
        .clr_i     (fifo_clr),
        .push_i    (sample_push),
        .data_i    (sample_data),
        .pop_i     (fifo_pop),
        .data_o    (fifo_head),
        .status_o  (fifo_status)
    );

    acq_sequencer u_acq_sequencer (
        .wbs_clk_i   (wbs_clk_i),
        .rst_i       (rst_i),
        .sensor_en_i (sensor_en),
        .spi_done_i  (spi_done),
        .spi_start_o (spi_start)
    );

    spi_deserializer #(.SCLK_DIV(SCLK_DIV)) u_spi_deserializer (
        .wbs_clk_i     (wbs_clk_i),
        .rst_i         (rst_i),
        .spi_start_i   (spi_start),
        .spi_done_o    (spi_done),
        .cs_n_o        (cs_n_o),
        .sclk_o        (sclk_o),
        .sdata_i       (sdata_i),
        .sample_data_o (sample_data),
        .sample_push_o (sample_push)
    );

endmodule

//--- tests/tb_sensor_hub.sv
`timescale 1ns/1ps

module tb_sensor_hub
    import sensor_hub_pkg::*;
;

    localparam int CLK_PERIOD  = 8;
    localparam int SCLK_DIV    = 2;
    localparam int XFER_CYCLES = 32 * 2 * SCLK_DIV + 2;
    localparam int WATCHDOG_CYCLES = 4 * 12 * (128 + 2) + 2000;
    localparam int ACK_LIMIT   = 32;
    localparam int POLL_LIMIT  = 2000;
    localparam int NUM_WORDS   = 12;
    // Positions of the expected values in the data file
    localparam int IDX_ID      = 12;
    localparam int IDX_REV     = 13;
    localparam int IDX_SCR_RST = 14;
    localparam int IDX_SCR_MRG = 15;
    localparam int IDX_DEF     = 16;
    localparam int IDX_BAD     = 17;
    localparam int IDX_EMPTY   = 18;
    localparam logic [ADDR_W-1:0] UNMAPPED_ADR = 17'h08000;

    logic        clk;
    logic        rst = 1'b1;
    wb_req_t     wb_req = '0;
    wb_rsp_t     wb_rsp;
    logic        cs_n;
    logic        sclk;
    logic        sdata = 1'b0;
    logic [31:0] vec [0:18];
    string       cur_test;
    int          test_errs;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          last_lat;
    int          exp_idx = 0;  // Next file word the host expects to read

    // Sensor model state
    int          widx;
    logic [4:0]  bidx;
    logic        cs_q;
    logic        sclk_q;

    sensor_hub_top #(.FIFO_DEPTH_LOG2(3), .SCLK_DIV(SCLK_DIV)) dut0 (
        .wbs_clk_i (clk),
        .rst_i     (rst),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .cs_n_o    (cs_n),
        .sclk_o    (sclk),
        .sdata_i   (sdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Shifts out one file word per frame, MSB first
    always @(posedge clk)
    begin
        cs_q   <= cs_n;
        sclk_q <= sclk;
        if (rst)
        begin
            widx  <= 0;
            bidx  <= 5'd31;
            cs_q  <= 1'b1;
            sdata <= vec[0][31];
        end
        else if (cs_n)
        begin
            bidx <= 5'd31;
            if (!cs_q)  // Frame just ended
            begin
                widx  <= (widx + 1) % NUM_WORDS;
                sdata <= vec[(widx + 1) % NUM_WORDS][31];
            end
        end
        else if (sclk && !sclk_q)
        begin
            bidx  <= bidx - 5'd1;
            sdata <= vec[widx][bidx - 5'd1];
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [ADDR_W-1:0] reg_addr(input logic [6:0] idx);
        return {REG_BASE[ADDR_W-1:9], idx, 2'b00};
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        test_errs++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errs++;
            $display("[ERROR] %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_status(input string what, input fifo_status_t exp,
                                input fifo_status_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errs++;
            $display("[ERROR] %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                              input logic [3:0] sel, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        wb_req_t req;
        int      n;
        req.adr = adr;
        req.sel = sel;
        req.we  = we;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.dat = wdat;
        n = 0;
        @(posedge clk);
        wb_req <= req;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!wb_rsp.ack && n < ACK_LIMIT);
        if (!wb_rsp.ack)
            report_failure($sformatf("bus access to %h was never acknowledged", adr));
        rdat     = wb_rsp.dat;
        last_lat = n - 1;
        req.cyc  = 1'b0;
        req.stb  = 1'b0;
        req.we   = 1'b0;
        wb_req <= req;  // stb drops for at least one cycle
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 4'hF, 32'h0, rdat);
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [3:0] sel,
                             input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, sel, wdat, unused);
    endtask

    task automatic read_status(output fifo_status_t st);
        logic [31:0] rd;
        bus_read(reg_addr(REG_STATUS_ADR), rd);
        st = rd[11:0];
    endtask

    task automatic poll_level(input logic [8:0] min_level);
        fifo_status_t st;
        int           n;
        st = '0;
        n  = 0;
        while (st.level < min_level && n < POLL_LIMIT)
        begin
            read_status(st);
            n++;
        end
        if (st.level < min_level)
            report_failure($sformatf("FIFO level never reached %0d", min_level));
    endtask

    // Quiet means cs_n stays high long enough that no new frame starts
    task automatic wait_sensor_idle();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 4 && n < 2 * XFER_CYCLES)
        begin
            @(posedge clk);
            n++;
            quiet = cs_n ? quiet + 1 : 0;
        end
        if (quiet < 4)
            report_failure("sensor transfers did not stop after disable");
    endtask

    task automatic read_samples(input int count);
        logic [31:0] rd;
        for (int i = 0; i < count; i++)
        begin
            bus_read(DPORT_BASE, rd);
            check_word($sformatf("sample %0d", exp_idx), vec[exp_idx % NUM_WORDS], rd);
            exp_idx++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
        tests++;
    endtask

    task automatic finish_test();
        if (test_errs == 0)
            $display("test %s: ok", cur_test);
        else
            $display("test %s: failed with %0d errors", cur_test, test_errs);
    endtask

    task automatic set_sensor(input logic en);
        bus_write(reg_addr(REG_SENSOR_EN_ADR), 4'h1, {31'b0, en});
    endtask

    initial
    begin
        logic [31:0]  rd;
        fifo_status_t st;
        $readmemh("tests/sensor_hub_input.txt", vec);
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset_defaults");
        check_word("cs_n idle", 32'd1, {31'b0, cs_n});
        check_word("sclk idle", 32'd0, {31'b0, sclk});
        bus_read(reg_addr(REG_ID_ADR), rd);
        check_word("ID", vec[IDX_ID], rd);
        check_word("ack latency", 32'd1, 32'(last_lat));
        bus_read(reg_addr(REG_REV_ADR), rd);
        check_word("REV", vec[IDX_REV], rd);
        bus_read(reg_addr(REG_SCRATCH_ADR), rd);
        check_word("SCRATCH", vec[IDX_SCR_RST], rd);
        read_status(st);
        check_status("STATUS", '{overrun: 1'b0, empty: 1'b1, full: 1'b0, level: 9'd0}, st);
        finish_test();

        begin_test("register_writes");
        bus_write(reg_addr(REG_SCRATCH_ADR), 4'b0101, 32'hAABB_CCDD);
        bus_read(reg_addr(REG_SCRATCH_ADR), rd);
        check_word("SCRATCH lanes 0 and 2", vec[IDX_SCR_MRG], rd);
        bus_read(reg_addr(7'h7F), rd);
        check_word("undefined index", vec[IDX_DEF], rd);
        finish_test();

        begin_test("unmapped_and_empty");
        bus_read(UNMAPPED_ADR, rd);
        check_word("unmapped read", vec[IDX_BAD], rd);
        check_word("unmapped ack latency", 32'(DEFAULT_TIMEOUT), 32'(last_lat));
        bus_write(UNMAPPED_ADR, 4'hF, 32'h0);
        check_word("unmapped write latency", 32'(DEFAULT_TIMEOUT), 32'(last_lat));
        bus_read(DPORT_BASE, rd);
        check_word("empty data port", vec[IDX_EMPTY], rd);
        read_status(st);
        check_status("STATUS after empty read",
                     '{overrun: 1'b0, empty: 1'b1, full: 1'b0, level: 9'd0}, st);
        finish_test();

        begin_test("acquisition");
        set_sensor(1'b1);
        poll_level(9'd4);
        set_sensor(1'b0);
        wait_sensor_idle();
        read_status(st);
        if (st.level < 9'd4)
            report_failure("fewer than four samples were captured");
        read_samples(int'(st.level));
        read_status(st);
        check_status("STATUS drained", '{overrun: 1'b0, empty: 1'b1, full: 1'b0, level: 9'd0}, st);
        finish_test();

        begin_test("overrun");
        set_sensor(1'b1);
        poll_level(9'd8);
        repeat (2 * XFER_CYCLES) @(posedge clk);  // Two words arrive with the FIFO full
        set_sensor(1'b0);
        wait_sensor_idle();
        read_status(st);
        check_status("STATUS full", '{overrun: 1'b1, empty: 1'b0, full: 1'b1, level: 9'd8}, st);
        read_samples(8);
        read_status(st);
        check_status("STATUS drained", '{overrun: 1'b1, empty: 1'b1, full: 1'b0, level: 9'd0}, st);
        finish_test();

        begin_test("fifo_reset");
        set_sensor(1'b1);
        poll_level(9'd2);
        set_sensor(1'b0);
        wait_sensor_idle();
        bus_write(reg_addr(REG_FIFO_RST_ADR), 4'hF, 32'h1);
        read_status(st);
        check_status("STATUS cleared", '{overrun: 1'b0, empty: 1'b1, full: 1'b0, level: 9'd0}, st);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- sensor_hub.f
hdl/sensor_hub_pkg.sv
hdl/wb_addr_decode.sv
hdl/fabric_regs.sv
hdl/sample_fifo.sv
hdl/acq_sequencer.sv
hdl/spi_deserializer.sv
hdl/sensor_hub_top.sv
tests/tb_sensor_hub.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sensor hub testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_sensor_hub \
    -f sensor_hub.f -o Vtb_sensor_hub
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sensor_hub > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
exit 1

//--- tests/sensor_hub_input.txt
// One 32-bit hex word per line
// Lines 0-11 sensor samples, then ID, REV, scratch reset, scratch after lanes 0 and 2, hole, unmapped, empty
80000001
A5A55A5A
01234567
FEDCBA98
13579BDF
2468ACE0
DEADBEEF
0F0FF0F0
7FFFFFFE
C3C33C3C
5555AAAA
89ABCDEF
00005E45
00000100
12345678
12BB56DD
FABDEFAC
BADFABAC
DEFFABAC
